//--- design/load_result.sv
`timescale 1ns/1ps

module load_result import lsu_pkg::*; (
  input  logic        clk_i,
  input  logic        rst_i,
  input  logic        ld_start_i,
  input  load_req_t   ld_req_i,
  input  rob_idx_t    ld_tag_i,
  input  fwd_resp_t   fwd_i,
  input  logic        rd_done_i,
  input  data_t       rd_data_i,
  input  logic        err_i,
  input  rob_idx_t    err_tag_i,
  output logic        load_busy_o,
  output logic        result_valid_o,
  output lsu_result_t result_o
);

  load_req_t   ld_q;
  rob_idx_t    tag_q;
  logic        busy_q;
  logic        valid_q;
  lsu_result_t res_q;
  logic [1:0]  fwd_lane;

  function automatic data_t format_load(data_t word, logic [1:0] lane, access_size_t size,
                                        logic sgn);
    data_t shifted;
    shifted = word >> {lane, 3'b000};
    case (size)
      BYTE:    return {{24{sgn & shifted[7]}}, shifted[7:0]};
      HALF:    return {{16{sgn & shifted[15]}}, shifted[15:0]};
      default: return shifted;
    endcase
  endfunction

  // Forwarded data is in store order, so the lane is relative to the store address
  assign fwd_lane = ld_req_i.addr[1:0] - fwd_i.addr[1:0];

  assign load_busy_o    = busy_q;
  assign result_valid_o = valid_q;
  assign result_o       = res_q;

  always_ff @(posedge clk_i) begin
    if (!rst_i) begin
      busy_q  <= 1'b0;
      valid_q <= 1'b0;
    end else begin
      valid_q <= 1'b0;
      if (err_i) begin
        valid_q          <= 1'b1;
        res_q.rob_idx    <= err_tag_i;
        res_q.data       <= '0;
        res_q.misaligned <= 1'b1;
      end else if (ld_start_i) begin
        tag_q <= ld_tag_i;
        ld_q  <= ld_req_i;
        if (fwd_i.hit) begin
          valid_q          <= 1'b1;
          res_q.rob_idx    <= ld_tag_i;
          res_q.data       <= format_load(fwd_i.data, fwd_lane, ld_req_i.size,
                                          ld_req_i.is_signed);
          res_q.misaligned <= 1'b0;
        end else begin
          busy_q <= 1'b1;  // Memory read outstanding
        end
      end
      if (rd_done_i && busy_q) begin
        busy_q           <= 1'b0;
        valid_q          <= 1'b1;
        res_q.rob_idx    <= tag_q;
        res_q.data       <= format_load(rd_data_i, ld_q.addr[1:0], ld_q.size, ld_q.is_signed);
        res_q.misaligned <= 1'b0;
      end
    end
  end

endmodule

//--- design/lsu_pkg.sv
package lsu_pkg;

  localparam int SB_DEPTH          = 4;
  localparam int SB_IDX_W          = 2;
  localparam int ROB_IDX_W         = 5;
  localparam int DRAIN_IDLE_CYCLES = 5;
  localparam int IDLE_CNT_W        = $clog2(DRAIN_IDLE_CYCLES + 1);

  typedef logic [31:0]          paddr_t;
  typedef logic [31:0]          data_t;
  typedef logic [ROB_IDX_W-1:0] rob_idx_t;

  typedef enum logic [1:0] {BYTE, HALF, WORD} access_size_t;
  typedef enum logic {LOAD, STORE} mem_kind_t;

  typedef struct packed {
    mem_kind_t    kind;
    access_size_t size;
    logic         is_signed;
    rob_idx_t     rob_idx;
    paddr_t       addr;
    data_t        data;  // Store data sits in the low bytes
  } lsu_op_t;

  typedef struct packed {
    rob_idx_t     rob_idx;
    paddr_t       addr;
    data_t        data;
    access_size_t size;
  } sb_store_t;

  typedef struct packed {
    paddr_t       addr;
    access_size_t size;
    logic         is_signed;
  } load_req_t;

  typedef struct packed {
    logic   hit;
    logic   must_wait;
    data_t  data;
    paddr_t addr;  // Address of the store that supplies the data
  } fwd_resp_t;

  typedef struct packed {
    rob_idx_t rob_idx;
    data_t    data;
    logic     misaligned;
  } lsu_result_t;

  typedef struct packed {
    logic         valid;
    logic         committed;
    rob_idx_t     rob_idx;
    paddr_t       addr;
    data_t        data;
    access_size_t size;
  } sb_entry_t;

endpackage

//--- design/lsu_top.sv
`timescale 1ns/1ps

module lsu_top import lsu_pkg::*; (
  input  logic        clk_i,
  input  logic        rst_i,
  input  logic        op_valid_i,
  input  lsu_op_t     op_i,
  output logic        op_ready_o,
  input  logic        commit_valid_i,
  input  rob_idx_t    commit_idx_i,
  input  logic        finish_i,
  output logic        done_o,
  output logic        result_valid_o,
  output lsu_result_t result_o,
  output logic        wb_cyc_o,
  output logic        wb_stb_o,
  output logic        wb_we_o,
  output logic [29:0] wb_adr_o,
  output logic [3:0]  wb_sel_o,
  output data_t       wb_dat_o,
  input  data_t       wb_dat_i,
  input  logic        wb_ack_i
);

  logic                     sb_push;
  sb_store_t                sb_store;
  logic                     ld_start;
  load_req_t                ld_req;
  logic                     err;
  rob_idx_t                 err_tag;
  logic                     sb_full;
  logic                     finish_mode;
  fwd_resp_t                fwd;
  logic                     load_busy;
  sb_entry_t [SB_DEPTH-1:0] entries;
  logic [SB_IDX_W-1:0]      tail;
  logic                     drain_req;
  sb_store_t                drain_store;
  logic                     drain_ack;
  logic                     rd_done;
  data_t                    rd_data;

  mem_op_decode i_decode (
    .clk_i        (clk_i),
    .rst_i        (rst_i),
    .op_valid_i   (op_valid_i),
    .op_i         (op_i),
    .op_ready_o   (op_ready_o),
    .sb_full_i    (sb_full),
    .finish_mode_i(finish_mode),
    .fwd_i        (fwd),
    .load_busy_i  (load_busy),
    .sb_push_o    (sb_push),
    .sb_store_o   (sb_store),
    .ld_start_o   (ld_start),
    .ld_req_o     (ld_req),
    .err_o        (err),
    .err_tag_o    (err_tag)
  );

  store_buffer i_store_buffer (
    .clk_i         (clk_i),
    .rst_i         (rst_i),
    .sb_push_i     (sb_push),
    .sb_store_i    (sb_store),
    .commit_valid_i(commit_valid_i),
    .commit_idx_i  (commit_idx_i),
    .finish_i      (finish_i),
    .entries_o     (entries),
    .tail_o        (tail),
    .sb_full_o     (sb_full),
    .finish_mode_o (finish_mode),
    .done_o        (done_o),
    .drain_req_o   (drain_req),
    .drain_store_o (drain_store),
    .drain_ack_i   (drain_ack)
  );

  store_forward_check i_forward (
    .ld_req_i (ld_req),
    .entries_i(entries),
    .tail_i   (tail),
    .fwd_o    (fwd)
  );

  wb_data_port i_wb_port (
    .clk_i        (clk_i),
    .rst_i        (rst_i),
    .ld_start_i   (ld_start),
    .ld_fwd_hit_i (fwd.hit),
    .ld_addr_i    (ld_req.addr),
    .drain_req_i  (drain_req),
    .drain_store_i(drain_store),
    .drain_ack_o  (drain_ack),
    .rd_done_o    (rd_done),
    .rd_data_o    (rd_data),
    .wb_cyc_o     (wb_cyc_o),
    .wb_stb_o     (wb_stb_o),
    .wb_we_o      (wb_we_o),
    .wb_adr_o     (wb_adr_o),
    .wb_sel_o     (wb_sel_o),
    .wb_dat_o     (wb_dat_o),
    .wb_dat_i     (wb_dat_i),
    .wb_ack_i     (wb_ack_i)
  );

  load_result i_result (
    .clk_i         (clk_i),
    .rst_i         (rst_i),
    .ld_start_i    (ld_start),
    .ld_req_i      (ld_req),
    .ld_tag_i      (op_i.rob_idx),
    .fwd_i         (fwd),
    .rd_done_i     (rd_done),
    .rd_data_i     (rd_data),
    .err_i         (err),
    .err_tag_i     (err_tag),
    .load_busy_o   (load_busy),
    .result_valid_o(result_valid_o),
    .result_o      (result_o)
  );

endmodule

//--- design/mem_op_decode.sv
`timescale 1ns/1ps

module mem_op_decode import lsu_pkg::*; (
  input  logic      clk_i,
  input  logic      rst_i,
  input  logic      op_valid_i,
  input  lsu_op_t   op_i,
  output logic      op_ready_o,
  input  logic      sb_full_i,
  input  logic      finish_mode_i,
  input  fwd_resp_t fwd_i,
  input  logic      load_busy_i,
  output logic      sb_push_o,
  output sb_store_t sb_store_o,
  output logic      ld_start_o,
  output load_req_t ld_req_o,
  output logic      err_o,
  output rob_idx_t  err_tag_o
);

  logic alive_q;
  logic misaligned;
  logic is_load;
  logic blocked;
  logic accept;

  always_ff @(posedge clk_i) begin
    if (!rst_i) begin
      alive_q <= 1'b0;
    end else begin
      alive_q <= 1'b1;  // Held low through reset so nothing is taken early
    end
  end

  always_comb begin
    case (op_i.size)
      HALF:    misaligned = op_i.addr[0];
      WORD:    misaligned = |op_i.addr[1:0];
      default: misaligned = 1'b0;
    endcase
  end

  assign is_load = (op_i.kind == LOAD);

  // Misaligned operations never touch the buffer, so only aligned ones can stall
  assign blocked = !misaligned && (is_load ? fwd_i.must_wait : sb_full_i);

  assign op_ready_o = alive_q && !load_busy_i && !finish_mode_i && !(op_valid_i && blocked);
  assign accept     = op_valid_i && op_ready_o;

  assign sb_push_o  = accept && !is_load && !misaligned;
  assign ld_start_o = accept && is_load && !misaligned;
  assign err_o      = accept && misaligned;
  assign err_tag_o  = op_i.rob_idx;

  assign sb_store_o.rob_idx = op_i.rob_idx;
  assign sb_store_o.addr    = op_i.addr;
  assign sb_store_o.data    = op_i.data;
  assign sb_store_o.size    = op_i.size;

  assign ld_req_o.addr      = op_i.addr;  // Drives the forward check before accept
  assign ld_req_o.size      = op_i.size;
  assign ld_req_o.is_signed = op_i.is_signed;

endmodule

//--- design/store_buffer.sv
`timescale 1ns/1ps

module store_buffer import lsu_pkg::*; (
  input  logic                     clk_i,
  input  logic                     rst_i,
  input  logic                     sb_push_i,
  input  sb_store_t                sb_store_i,
  input  logic                     commit_valid_i,
  input  rob_idx_t                 commit_idx_i,
  input  logic                     finish_i,
  output sb_entry_t [SB_DEPTH-1:0] entries_o,
  output logic [SB_IDX_W-1:0]      tail_o,
  output logic                     sb_full_o,
  output logic                     finish_mode_o,
  output logic                     done_o,
  output logic                     drain_req_o,
  output sb_store_t                drain_store_o,
  input  logic                     drain_ack_i
);

  sb_entry_t [SB_DEPTH-1:0] entries_q;
  logic [SB_IDX_W-1:0]      head_q;
  logic [SB_IDX_W-1:0]      tail_q;
  logic [SB_IDX_W:0]        count_q;
  logic                     finish_mode_q;
  logic [IDLE_CNT_W-1:0]    idle_cnt_q;
  sb_entry_t                head;
  logic                     head_committing;
  logic                     empty;

  assign head  = entries_q[head_q];
  assign empty = (count_q == '0);

  // A commit in this very cycle is enough to start the write
  assign head_committing = commit_valid_i && (head.rob_idx == commit_idx_i);

  assign drain_req_o = head.valid && (head.committed || head_committing || finish_mode_q);

  assign drain_store_o.rob_idx = head.rob_idx;
  assign drain_store_o.addr    = head.addr;
  assign drain_store_o.data    = head.data;
  assign drain_store_o.size    = head.size;

  assign entries_o     = entries_q;
  assign tail_o        = tail_q;
  assign sb_full_o     = (count_q == (SB_IDX_W + 1)'(SB_DEPTH));
  assign finish_mode_o = finish_mode_q;
  assign done_o        = finish_i && finish_mode_q &&
                         (idle_cnt_q == IDLE_CNT_W'(DRAIN_IDLE_CYCLES));

  always_ff @(posedge clk_i) begin
    if (!rst_i) begin
      head_q        <= '0;
      tail_q        <= '0;
      count_q       <= '0;
      finish_mode_q <= 1'b0;
      idle_cnt_q    <= '0;
      for (int i = 0; i < SB_DEPTH; i++) begin
        entries_q[i].valid     <= 1'b0;
        entries_q[i].committed <= 1'b0;
      end
    end else begin
      if (finish_i) begin
        finish_mode_q <= 1'b1;
      end else if (empty) begin
        finish_mode_q <= 1'b0;  // Leave finish mode only once nothing is left
      end

      if (finish_mode_q && empty) begin
        if (idle_cnt_q != IDLE_CNT_W'(DRAIN_IDLE_CYCLES)) begin
          idle_cnt_q <= idle_cnt_q + 1'b1;
        end
      end else begin
        idle_cnt_q <= '0;
      end

      if (commit_valid_i) begin
        for (int i = 0; i < SB_DEPTH; i++) begin
          if (entries_q[i].valid && (entries_q[i].rob_idx == commit_idx_i)) begin
            entries_q[i].committed <= 1'b1;
          end
        end
      end

      if (sb_push_i) begin
        entries_q[tail_q].valid     <= 1'b1;
        entries_q[tail_q].committed <= 1'b0;
        entries_q[tail_q].rob_idx   <= sb_store_i.rob_idx;
        entries_q[tail_q].addr      <= sb_store_i.addr;
        entries_q[tail_q].data      <= sb_store_i.data;
        entries_q[tail_q].size      <= sb_store_i.size;
        tail_q                      <= tail_q + 1'b1;
      end

      if (drain_ack_i) begin
        entries_q[head_q].valid     <= 1'b0;
        entries_q[head_q].committed <= 1'b0;
        head_q                      <= head_q + 1'b1;
      end

      count_q <= count_q + {{SB_IDX_W{1'b0}}, sb_push_i} - {{SB_IDX_W{1'b0}}, drain_ack_i};
    end
  end

endmodule

//--- design/store_forward_check.sv
`timescale 1ns/1ps

module store_forward_check import lsu_pkg::*; (
  input  load_req_t                ld_req_i,
  input  sb_entry_t [SB_DEPTH-1:0] entries_i,
  input  logic [SB_IDX_W-1:0]      tail_i,
  output fwd_resp_t                fwd_o
);

  function automatic logic [32:0] access_end(paddr_t addr, access_size_t size);
    logic [32:0] nbytes;
    case (size)
      BYTE:    nbytes = 33'd1;
      HALF:    nbytes = 33'd2;
      default: nbytes = 33'd4;
    endcase
    return {1'b0, addr} + nbytes;  // One past the last byte, kept wide so it never wraps
  endfunction

  always_comb begin : search
    logic [SB_IDX_W-1:0] idx;
    logic [32:0]         ld_lo;
    logic [32:0]         ld_hi;
    logic [32:0]         st_lo;
    logic [32:0]         st_hi;
    logic                found;

    fwd_o = '0;
    found = 1'b0;
    idx   = '0;
    st_lo = '0;
    st_hi = '0;
    ld_lo = {1'b0, ld_req_i.addr};
    ld_hi = access_end(ld_req_i.addr, ld_req_i.size);

    // The slot just below the tail is the youngest store
    for (int i = 0; i < SB_DEPTH; i++) begin
      idx   = tail_i - SB_IDX_W'(i + 1);
      st_lo = {1'b0, entries_i[idx].addr};
      st_hi = access_end(entries_i[idx].addr, entries_i[idx].size);
      if (!found && entries_i[idx].valid && (st_lo < ld_hi) && (ld_lo < st_hi)) begin
        found = 1'b1;
        if ((st_lo <= ld_lo) && (ld_hi <= st_hi)) begin
          fwd_o.hit  = 1'b1;
          fwd_o.data = entries_i[idx].data;
          fwd_o.addr = entries_i[idx].addr;
        end else begin
          fwd_o.must_wait = 1'b1;  // Mixed bytes, wait until this store is in memory
        end
      end
    end
  end

endmodule

//--- design/wb_data_port.sv
`timescale 1ns/1ps

module wb_data_port import lsu_pkg::*; (
  input  logic        clk_i,
  input  logic        rst_i,
  input  logic        ld_start_i,
  input  logic        ld_fwd_hit_i,
  input  paddr_t      ld_addr_i,
  input  logic        drain_req_i,
  input  sb_store_t   drain_store_i,
  output logic        drain_ack_o,
  output logic        rd_done_o,
  output data_t       rd_data_o,
  output logic        wb_cyc_o,
  output logic        wb_stb_o,
  output logic        wb_we_o,
  output logic [29:0] wb_adr_o,
  output logic [3:0]  wb_sel_o,
  output data_t       wb_dat_o,
  input  data_t       wb_dat_i,
  input  logic        wb_ack_i
);

  typedef enum logic [1:0] {ST_IDLE, ST_READ, ST_WRITE} wb_state_t;

  wb_state_t state_q;
  logic      rd_pend_q;
  paddr_t    rd_addr_q;
  logic      rd_new;
  paddr_t    rd_addr;

  function automatic logic [3:0] byte_sel(access_size_t size, logic [1:0] lane);
    case (size)
      BYTE:    return 4'b0001 << lane;
      HALF:    return 4'b0011 << lane;
      default: return 4'b1111;
    endcase
  endfunction

  assign rd_new  = ld_start_i && !ld_fwd_hit_i;
  assign rd_addr = rd_new ? ld_addr_i : rd_addr_q;

  assign wb_cyc_o    = (state_q != ST_IDLE);
  assign wb_stb_o    = (state_q != ST_IDLE);
  assign drain_ack_o = (state_q == ST_WRITE) && wb_ack_i;
  assign rd_done_o   = (state_q == ST_READ) && wb_ack_i;
  assign rd_data_o   = wb_dat_i;

  always_ff @(posedge clk_i) begin
    if (!rst_i) begin
      state_q   <= ST_IDLE;
      rd_pend_q <= 1'b0;
      wb_we_o   <= 1'b0;
    end else begin
      if (rd_new) begin
        rd_pend_q <= 1'b1;  // Parked here while a write still owns the bus
        rd_addr_q <= ld_addr_i;
      end
      case (state_q)
        ST_IDLE: begin
          if (rd_new || rd_pend_q) begin
            state_q   <= ST_READ;
            rd_pend_q <= 1'b0;
            wb_we_o   <= 1'b0;
            wb_adr_o  <= rd_addr[31:2];
            wb_sel_o  <= 4'b1111;
          end else if (drain_req_i) begin
            state_q  <= ST_WRITE;
            wb_we_o  <= 1'b1;
            wb_adr_o <= drain_store_i.addr[31:2];
            wb_sel_o <= byte_sel(drain_store_i.size, drain_store_i.addr[1:0]);
            wb_dat_o <= drain_store_i.data << {drain_store_i.addr[1:0], 3'b000};
          end
        end
        ST_READ, ST_WRITE: begin
          if (wb_ack_i) begin
            state_q <= ST_IDLE;
          end
        end
        default: state_q <= ST_IDLE;
      endcase
    end
  end

endmodule

//--- run_sim.sh
#!/usr/bin/env bash
set -u

cd "$(dirname "$0")" || exit 1
LOG=sim.log

verilator --binary --timing --top-module tb_lsu_top -f tb.f -Mdir obj_dir
if [ $? -ne 0 ]; then
  echo "Verilator build failed"
  exit 1
fi

./obj_dir/Vtb_lsu_top > "$LOG" 2>&1
run_status=$?
cat "$LOG"
if [ $run_status -ne 0 ]; then
  echo "Simulator exited with status $run_status"
  exit 1
fi

if grep -qx "Simulation PASSED" "$LOG"; then
  exit 0
fi
exit 1

//--- tb.f
design/lsu_pkg.sv
design/mem_op_decode.sv
design/store_buffer.sv
design/store_forward_check.sv
design/wb_data_port.sv
design/load_result.sv
design/lsu_top.sv
verification/tb_lsu_top.sv

//--- verification/tb_lsu_top.sv
`timescale 1ns/1ps

module tb_lsu_top import lsu_pkg::*; ();

  localparam logic [31:0] SEED = 32'h8586;
  localparam int N_DIRECTED     = 9;
  localparam int N_RANDOM       = 400;
  localparam int N_FINISH       = 3;
  localparam int N_OPS          = N_DIRECTED + N_RANDOM + N_FINISH;
  localparam int TIMEOUT_CYCLES = 20 * N_OPS + 2000;

  logic        clk_i = 1'b0;
  logic        rst_i;
  logic        op_valid_i;
  lsu_op_t     op_i;
  logic        op_ready_o;
  logic        commit_valid_i;
  rob_idx_t    commit_idx_i;
  logic        finish_i;
  logic        done_o;
  logic        result_valid_o;
  lsu_result_t result_o;
  logic        wb_cyc_o;
  logic        wb_stb_o;
  logic        wb_we_o;
  logic [29:0] wb_adr_o;
  logic [3:0]  wb_sel_o;
  data_t       wb_dat_o;
  data_t       wb_dat_i;
  logic        wb_ack_i;

  logic [7:0]  shadow [0:255];  // Program-order image of memory
  data_t       mem [0:63];
  lsu_result_t exp_q [$];
  rob_idx_t    commit_q [$];
  paddr_t      store_log [$];    // Aligned stores in drain order
  rob_idx_t    next_tag;
  logic        commit_en;
  int          err_main;
  int          err_result;
  int          err_write;
  int          commits_seen;
  int          writes_seen;
  logic        finish_seen;
  logic        write_active;
  int          cycle_cnt;

  lsu_top i_dut (
    .clk_i         (clk_i),
    .rst_i         (rst_i),
    .op_valid_i    (op_valid_i),
    .op_i          (op_i),
    .op_ready_o    (op_ready_o),
    .commit_valid_i(commit_valid_i),
    .commit_idx_i  (commit_idx_i),
    .finish_i      (finish_i),
    .done_o        (done_o),
    .result_valid_o(result_valid_o),
    .result_o      (result_o),
    .wb_cyc_o      (wb_cyc_o),
    .wb_stb_o      (wb_stb_o),
    .wb_we_o       (wb_we_o),
    .wb_adr_o      (wb_adr_o),
    .wb_sel_o      (wb_sel_o),
    .wb_dat_o      (wb_dat_o),
    .wb_dat_i      (wb_dat_i),
    .wb_ack_i      (wb_ack_i)
  );

  always #50 clk_i = ~clk_i;

  function automatic logic [31:0] lcg_next(input logic [31:0] s);
    return s * 32'd1664525 + 32'd1013904223;
  endfunction

  // Every byte holds its own address, scrambled
  function automatic data_t init_word(input int w);
    logic [7:0] b;
    b = 8'(4 * w);
    return {b + 8'd3, b + 8'd2, b + 8'd1, b} ^ 32'ha5a5a5a5;
  endfunction

  function automatic int size_bytes(input access_size_t size);
    case (size)
      BYTE:    return 1;
      HALF:    return 2;
      default: return 4;
    endcase
  endfunction

  function automatic logic is_misaligned(input lsu_op_t op);
    return ((op.size == HALF) && op.addr[0]) || ((op.size == WORD) && (op.addr[1:0] != 2'b00));
  endfunction

  function automatic data_t expected_load(input logic [7:0] bytes [0:255], input logic [7:0] addr,
                                          input access_size_t size, input logic sgn);
    data_t v;
    v = '0;
    for (int i = 0; i < size_bytes(size); i++) begin
      v[8*i +: 8] = bytes[addr + 8'(i)];
    end
    if (sgn && (size == BYTE) && v[7]) begin
      v[31:8] = '1;
    end
    if (sgn && (size == HALF) && v[15]) begin
      v[31:16] = '1;
    end
    return v;
  endfunction

  function automatic lsu_op_t make_op(input mem_kind_t kind, input access_size_t size,
                                      input logic sgn, input paddr_t addr, input data_t data);
    lsu_op_t op;
    op           = '0;
    op.kind      = kind;
    op.size      = size;
    op.is_signed = sgn;
    op.addr      = addr;
    op.data      = data;
    return op;
  endfunction

  // Mostly a 32-byte window so that stores and loads collide often
  function automatic lsu_op_t random_op(input logic [31:0] r1, input logic [31:0] r2);
    lsu_op_t op;
    op           = '0;
    op.kind      = r1[31] ? STORE : LOAD;
    case (r1[30:29])
      2'd0:    op.size = BYTE;
      2'd1:    op.size = HALF;
      default: op.size = WORD;
    endcase
    op.is_signed = r1[28];
    op.addr      = (r1[27:25] == 3'd0) ? {24'd0, r1[23:16]} : {27'd0, r1[20:16]};
    if (r1[14:12] != 3'd0) begin
      if (op.size == HALF) op.addr[0] = 1'b0;
      if (op.size == WORD) op.addr[1:0] = 2'b00;
    end
    op.data = r2;
    return op;
  endfunction

  task automatic record_accept(input lsu_op_t op);
    lsu_result_t exp;
    exp.rob_idx    = op.rob_idx;
    exp.data       = '0;
    exp.misaligned = is_misaligned(op);
    if (exp.misaligned) begin
      exp_q.push_back(exp);
    end else if (op.kind == LOAD) begin
      exp.data = expected_load(shadow, op.addr[7:0], op.size, op.is_signed);
      exp_q.push_back(exp);
    end else begin
      for (int i = 0; i < size_bytes(op.size); i++) begin
        shadow[op.addr[7:0] + 8'(i)] = op.data[8*i +: 8];
      end
      commit_q.push_back(op.rob_idx);
      store_log.push_back(op.addr);
    end
  endtask

  // Called 1 ns after a rising edge, returns 1 ns after the accept edge
  task automatic issue_op(input lsu_op_t op_in);
    lsu_op_t op;
    logic    taken;
    op         = op_in;
    op.rob_idx = next_tag;
    next_tag   = next_tag + 1'b1;
    op_i       = op;
    op_valid_i = 1'b1;
    taken      = 1'b0;
    while (!taken) begin
      @(negedge clk_i);
      taken = op_ready_o;
      if (taken) record_accept(op);
      @(posedge clk_i);
      #1;
    end
    op_valid_i = 1'b0;
  endtask

  // Wishbone slave with 0 to 3 extra wait states
  initial begin
    logic [31:0] mem_seed;
    logic [1:0]  wait_cnt;
    logic [1:0]  wait_target;
    logic        give_ack;
    logic        we;
    logic [5:0]  widx;
    logic [3:0]  sel;
    data_t       wdat;
    wb_ack_i    = 1'b0;
    wb_dat_i    = '0;
    mem_seed    = SEED ^ 32'h3c3c0000;
    wait_cnt    = '0;
    wait_target = '0;
    for (int w = 0; w < 64; w++) begin
      mem[w] = init_word(w);
    end
    forever begin
      @(negedge clk_i);
      give_ack = 1'b0;
      we       = wb_we_o;
      widx     = wb_adr_o[5:0];
      sel      = wb_sel_o;
      wdat     = wb_dat_o;
      if (wb_cyc_o && wb_stb_o && !wb_ack_i) begin
        if (wait_cnt == wait_target) begin
          give_ack    = 1'b1;
          wait_cnt    = '0;
          mem_seed    = lcg_next(mem_seed);
          wait_target = mem_seed[31:30];
        end else begin
          wait_cnt = wait_cnt + 1'b1;
        end
      end
      @(posedge clk_i);
      #1;
      wb_ack_i = give_ack;
      if (give_ack && we) begin
        for (int b = 0; b < 4; b++) begin
          if (sel[b]) mem[widx][8*b +: 8] = wdat[8*b +: 8];
        end
      end else if (give_ack) begin
        wb_dat_i = mem[widx];
      end
    end
  end

  // Commits follow program order over the accepted stores
  initial begin
    logic [31:0] cm_seed;
    commit_valid_i = 1'b0;
    commit_idx_i   = '0;
    cm_seed        = SEED ^ 32'h00005a5a;
    forever begin
      @(posedge clk_i);
      #1;
      cm_seed = lcg_next(cm_seed);
      if (commit_en && (commit_q.size() != 0) && (cm_seed[31:30] == 2'd0)) begin
        commit_valid_i = 1'b1;
        commit_idx_i   = commit_q.pop_front();
      end else begin
        commit_valid_i = 1'b0;
      end
    end
  end

  always @(negedge clk_i) begin
    lsu_result_t exp;
    if (rst_i && result_valid_o) begin
      if (exp_q.size() == 0) begin
        err_result++;
        $display("[FAIL] %0t: result with tag %0d arrived with no operation waiting for it",
                 $time, result_o.rob_idx);
      end else begin
        exp = exp_q.pop_front();
        if ((result_o.rob_idx !== exp.rob_idx) || (result_o.misaligned !== exp.misaligned) ||
            (!exp.misaligned && (result_o.data !== exp.data))) begin
          err_result++;
          $display("[FAIL] %0t: result tag %0d data %08h mis %0b, expected tag %0d data %08h mis %0b",
                   $time, result_o.rob_idx, result_o.data, result_o.misaligned,
                   exp.rob_idx, exp.data, exp.misaligned);
        end
      end
    end
  end

  // A write may start only after its store was committed, or in finish mode
  always @(negedge clk_i) begin
    paddr_t a;
    if (rst_i) begin
      if (wb_cyc_o && wb_we_o && !write_active) begin
        if (store_log.size() == 0) begin
          err_write++;
          $display("A Wishbone write started at %0t with no store left to drain", $time);
        end else begin
          a = store_log.pop_front();
          if (wb_adr_o !== a[31:2]) begin
            err_write++;
            $display("[FAIL] %0t: write to word %08h, expected word %08h", $time,
                     wb_adr_o, a[31:2]);
          end
          if (!finish_seen && (commits_seen <= writes_seen)) begin
            err_write++;
            $display("[FAIL] %0t: store to %08h written before its commit", $time, a);
          end
          writes_seen++;
        end
      end
      write_active = wb_cyc_o && wb_we_o;
      if (commit_valid_i) commits_seen++;
      if (finish_i) finish_seen = 1'b1;
    end
  end

  always @(posedge clk_i) begin
    cycle_cnt++;
    if (cycle_cnt >= TIMEOUT_CYCLES) begin
      $display("Timeout after %0d cycles, the operations did not all complete", cycle_cnt);
      $display("Simulation FAILED");
      $finish;
    end
  end

  initial begin
    logic [31:0] st_seed;
    logic [31:0] r1;
    data_t       init_w;
    int          total;
    rst_i        = 1'b0;
    op_valid_i   = 1'b0;
    op_i         = '0;
    finish_i     = 1'b0;
    next_tag     = '0;
    commit_en    = 1'b1;
    err_main     = 0;
    err_result   = 0;
    err_write    = 0;
    commits_seen = 0;
    writes_seen  = 0;
    finish_seen  = 1'b0;
    write_active = 1'b0;
    cycle_cnt    = 0;
    st_seed      = SEED;
    for (int b = 0; b < 256; b++) begin
      init_w    = init_word(b / 4);
      shadow[b] = init_w[8*(b%4) +: 8];
    end

    repeat (5) @(posedge clk_i);
    @(negedge clk_i);
    if (op_ready_o || result_valid_o || done_o || wb_cyc_o || wb_stb_o) begin
      err_main++;
      $display("Outputs were not idle during reset at %0t", $time);
    end
    repeat (5) @(posedge clk_i);
    #1;
    rst_i = 1'b1;

    issue_op(make_op(STORE, WORD, 1'b0, 32'h40, 32'h80ff7f01));
    issue_op(make_op(LOAD, BYTE, 1'b1, 32'h43, '0));     // Forwarded, sign extended
    issue_op(make_op(LOAD, HALF, 1'b0, 32'h42, '0));
    issue_op(make_op(LOAD, BYTE, 1'b1, 32'h42, '0));
    issue_op(make_op(STORE, BYTE, 1'b0, 32'h41, 32'h000000aa));
    issue_op(make_op(LOAD, WORD, 1'b0, 32'h40, '0));     // Partial overlap, waits for drain
    issue_op(make_op(LOAD, WORD, 1'b0, 32'h42, '0));
    issue_op(make_op(STORE, HALF, 1'b0, 32'h45, 32'h00001234));
    issue_op(make_op(LOAD, WORD, 1'b0, 32'h44, '0));

    for (int n = 0; n < N_RANDOM; n++) begin
      st_seed = lcg_next(st_seed);
      r1      = st_seed;
      st_seed = lcg_next(st_seed);
      issue_op(random_op(r1, st_seed));
    end

    while ((exp_q.size() != 0) || (commit_q.size() != 0)) @(negedge clk_i);
    @(posedge clk_i);
    #1;
    commit_en = 1'b0;
    issue_op(make_op(STORE, WORD, 1'b0, 32'h10, 32'hdeadbeef));
    issue_op(make_op(STORE, HALF, 1'b0, 32'h16, 32'h0000c001));
    issue_op(make_op(STORE, BYTE, 1'b0, 32'h11, 32'h0000007e));
    if (done_o) begin
      err_main++;
      $display("done_o was high at %0t before finish was requested", $time);
    end
    finish_i = 1'b1;
    @(negedge clk_i);
    @(negedge clk_i);
    if (op_ready_o) begin
      err_main++;
      $display("op_ready_o stayed high at %0t in finish mode", $time);
    end
    while (!done_o) @(negedge clk_i);
    repeat (2) @(negedge clk_i);
    if (!done_o) begin
      err_main++;
      $display("done_o dropped at %0t while finish_i was still high", $time);
    end
    if ((store_log.size() != 0) || (exp_q.size() != 0)) begin
      err_main++;
      $display("%0d stores and %0d results were still outstanding after done",
               store_log.size(), exp_q.size());
    end
    for (int b = 0; b < 256; b++) begin
      if (mem[b / 4][8*(b%4) +: 8] !== shadow[b]) begin
        err_main++;
        $display("[FAIL] %0t: memory byte %02h is %02h, expected %02h", $time, b,
                 mem[b / 4][8*(b%4) +: 8], shadow[b]);
      end
    end

    total = err_main + err_result + err_write;
    $display("Errors: result %0d, write %0d, other %0d, total %0d",
             err_result, err_write, err_main, total);
    if (total == 0) begin
      $display("Simulation PASSED");
    end else begin
      $display("Simulation FAILED");
    end
    $finish;
  end

endmodule
